// ==== vlog.f ====
+incdir+hw
hw/ib_pkg.sv
hw/bank_fifo.sv
hw/fetch_aligner.sv
hw/instr_buffer.sv
hw/ib_frontend_top.sv
bench/ib_tb.sv

// ==== bench/ib_tb.sv ====
`timescale 1ns/1ps
`include "ib_params.svh"

module ib_tb
    import ib_pkg::*;
();

    localparam int FW   = `IB_FETCH_WIDTH;
    localparam int DW   = `IB_DECODE_WIDTH;
    localparam int SIZE = `IB_SIZE;

    // All directed tests together take roughly this many cycles
    localparam int TEST_CYCLES    = 500;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic         clk;
    logic         arst_n;
    fetch_block_t fetch;
    pop_cnt_t     accept_cnt;
    logic         flush;
    logic         stall_req;
    instr_info_t  decode_out [`IB_DECODE_WIDTH];

    // Expected buffer contents with the oldest first
    instr_info_t  model_q [$];
    logic [31:0]  lcg_state;
    string        test_name;
    int           cycle_count;

    ib_frontend_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch      (fetch),
        .accept_cnt (accept_cnt),
        .flush      (flush),
        .stall_req  (stall_req),
        .decode_out (decode_out)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits of the LCG are the better mixed ones
    function automatic int rand_below(input int n);
        return int'((next_random() >> 16) % n);
    endfunction

    function automatic fetch_block_t build_block(input logic [31:0] pc);
        fetch_block_t blk;
        blk.valid = 1'b1;
        blk.pc    = pc;
        for (int k = 0; k < FW; k++) begin
            blk.words[k] = next_random();
        end
        return blk;
    endfunction

    // Backend never takes more than it sees
    function automatic pop_cnt_t clamp_accept(input int want);
        int lanes;
        lanes = (model_q.size() < DW) ? model_q.size() : DW;
        return pop_cnt_t'((want < lanes) ? want : lanes);
    endfunction

    // Whether the block now on the fetch port goes in at the next edge
    function automatic logic block_taken_next();
        return fetch.valid && !flush && (model_q.size() <= SIZE - FW);
    endfunction

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error %s %s: expected %b actual %b", test_name, what, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_instr(input string what, input instr_info_t exp,
                               input instr_info_t act);
        if (exp !== act) begin
            $display("error %s %s: expected %b/%h/%h actual %b/%h/%h",
                     test_name, what, exp.valid, exp.pc, exp.instr,
                     act.valid, act.pc, act.instr);
            stop_with_failure();
        end
    endtask

    // Applies the inputs seen at this edge to the expected contents
    task automatic model_update();
        logic        stalled;
        int          slot;
        logic [31:0] line_base;
        instr_info_t item;
        stalled = (model_q.size() > SIZE - FW);
        if (flush) begin
            model_q.delete();
        end else begin
            for (int i = 0; i < int'(accept_cnt); i++) begin
                void'(model_q.pop_front());
            end
            if (fetch.valid && !stalled) begin
                slot      = int'((fetch.pc / 4) % FW);
                line_base = fetch.pc - (fetch.pc % (4 * FW));
                for (int k = slot; k < FW; k++) begin
                    item.valid = 1'b1;
                    item.pc    = line_base + 32'(4 * k);
                    item.instr = fetch.words[k];
                    model_q.push_back(item);
                end
            end
        end
    endtask

    task automatic check_outputs();
        for (int j = 0; j < DW; j++) begin
            check_bit($sformatf("lane %0d valid", j), model_q.size() > j,
                      decode_out[j].valid);
            if (model_q.size() > j) begin
                check_instr($sformatf("lane %0d", j), model_q[j], decode_out[j]);
            end
        end
        check_bit("stall_req", model_q.size() > SIZE - FW, stall_req);
    endtask

    // Models the edge, drives new inputs and checks once settled
    task automatic run_cycle(input fetch_block_t blk, input int want_accept,
                             input logic do_flush);
        @(posedge clk);
        model_update();
        fetch      <= blk;
        accept_cnt <= clamp_accept(want_accept);
        flush      <= do_flush;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic drain();
        run_cycle('0, 2, 1'b0);
        while (model_q.size() != 0) begin
            run_cycle('0, 2, 1'b0);
        end
    endtask

    task automatic test_aligned();
        test_name = "aligned";
        run_cycle(build_block(32'h0000_1000), 2, 1'b0);
        drain();
    endtask

    // Slot 3 gives one instruction and slot 1 gives three
    task automatic test_misaligned();
        test_name = "misaligned";
        run_cycle(build_block(32'h0000_200c), 2, 1'b0);
        run_cycle(build_block(32'h0000_2014), 2, 1'b0);
        drain();
    endtask

    task automatic test_backpressure();
        fetch_block_t held;
        test_name = "backpressure";
        // Odd first block so the bank pointers sit off zero
        run_cycle(build_block(32'h0000_3004), 0, 1'b0);
        for (int i = 1; i < 4; i++) begin
            run_cycle(build_block(32'h0000_3000 + 32'(16 * i)), 0, 1'b0);
        end
        // Occupancy reaches 15 so this one waits
        held = build_block(32'h0000_3040);
        repeat (4) begin
            run_cycle(held, 0, 1'b0);
        end
        while (!block_taken_next()) begin
            run_cycle(held, 2, 1'b0);
        end
        drain();
    endtask

    task automatic test_random();
        fetch_block_t blk;
        test_name = "random";
        for (int n = 0; n < 300; n++) begin
            if (fetch.valid && !block_taken_next()) begin
                blk = fetch;
            end else if (rand_below(4) != 0) begin
                blk = build_block(32'h0000_8000 + 32'(16 * n) + 32'(4 * rand_below(FW)));
            end else begin
                blk = '0;
            end
            run_cycle(blk, rand_below(DW + 1), 1'b0);
        end
        drain();
    endtask

    task automatic test_flush();
        test_name = "flush";
        run_cycle(build_block(32'h0000_9000), 1, 1'b0);
        run_cycle(build_block(32'h0000_9010), 1, 1'b0);
        run_cycle(build_block(32'h0000_9020), 1, 1'b0);
        // Block offered together with the flush is dropped
        run_cycle(build_block(32'h0000_9030), 1, 1'b1);
        run_cycle('0, 0, 1'b0);
        check_bit("lane 0 valid after flush", 1'b0, decode_out[0].valid);
        check_bit("lane 1 valid after flush", 1'b0, decode_out[1].valid);
        check_bit("stall_req after flush", 1'b0, stall_req);
        run_cycle(build_block(32'h0000_9104), 2, 1'b0);
        run_cycle(build_block(32'h0000_9110), 2, 1'b0);
        drain();
    endtask

    initial begin
        lcg_state   = 32'h262a233b;
        cycle_count = 0;
        test_name   = "reset";
        arst_n      = 1'b0;
        fetch       = '0;
        accept_cnt  = '0;
        flush       = 1'b0;
        repeat (8) begin
            @(posedge clk);
        end
        arst_n <= 1'b1;
        @(negedge clk);
        check_outputs();

        test_aligned();
        test_misaligned();
        test_backpressure();
        test_random();
        test_flush();

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== hw/ib_frontend_top.sv ====
`timescale 1ns/1ps
`include "ib_params.svh"

module ib_frontend_top
    import ib_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  fetch_block_t fetch,
    input  pop_cnt_t     accept_cnt,
    input  logic         flush,
    output logic         stall_req,
    output instr_info_t  decode_out [`IB_DECODE_WIDTH]
);

    // Compacted block, lane 0 first
    instr_info_t fetch_lanes [`IB_FETCH_WIDTH];
    push_cnt_t   fetch_cnt;

    fetch_aligner u_aligner (
        .fetch    (fetch),
        .lanes    (fetch_lanes),
        .push_cnt (fetch_cnt)
    );

    // Stall and flush gating of the push happen inside the buffer
    instr_buffer u_buffer (
        .clk        (clk),
        .arst_n     (arst_n),
        .lanes_in   (fetch_lanes),
        .push_cnt   (fetch_cnt),
        .accept_cnt (accept_cnt),
        .flush      (flush),
        .stall_req  (stall_req),
        .decode_out (decode_out)
    );

endmodule

// ==== hw/instr_buffer.sv ====
`timescale 1ns/1ps
`include "ib_params.svh"

module instr_buffer
    import ib_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  instr_info_t lanes_in [`IB_FETCH_WIDTH],
    input  push_cnt_t   push_cnt,
    input  pop_cnt_t    accept_cnt,
    input  logic        flush,
    output logic        stall_req,
    output instr_info_t decode_out [`IB_DECODE_WIDTH]
);

    localparam int CH   = `IB_CHANNELS;
    localparam int FW   = `IB_FETCH_WIDTH;
    localparam int DW   = `IB_DECODE_WIDTH;
    localparam int SIZE = `IB_SIZE;

    // Bank that takes the next pushed instruction
    bank_idx_t wr_ptr;
    // Bank holding the oldest instruction
    bank_idx_t rd_ptr;
    occ_t      occ;

    push_cnt_t push_num;
    pop_cnt_t  pop_num;
    pop_cnt_t  valid_lanes;

    logic [CH-1:0] bank_push;
    logic [CH-1:0] bank_pop;
    logic [CH-1:0] bank_full;
    logic [CH-1:0] bank_empty;
    instr_info_t   bank_in  [CH];
    instr_info_t   bank_out [CH];

    // Not enough room for a whole block
    assign stall_req = (occ > occ_t'(SIZE - FW));

    // A stalled or flushed block is dropped, the frontend holds it
    assign push_num = (stall_req || flush) ? '0 : push_cnt;
    assign pop_num  = flush ? '0 : accept_cnt;

    assign valid_lanes = (occ >= occ_t'(DW)) ? pop_cnt_t'(DW) : pop_cnt_t'(occ);

    // Consecutive instructions land in consecutive banks
    for (genvar b = 0; b < CH; b++) begin : gen_bank
        // Distance of this bank from the write and read pointers
        bank_idx_t wr_rel;
        bank_idx_t rd_rel;

        assign wr_rel = bank_idx_t'(b) - wr_ptr;
        assign rd_rel = bank_idx_t'(b) - rd_ptr;

        assign bank_push[b] = (wr_rel < push_num);
        assign bank_pop[b]  = (rd_rel < pop_num);
        assign bank_in[b]   = (int'(wr_rel) < FW) ? lanes_in[wr_rel] : '0;

        bank_fifo u_bank (
            .clk       (clk),
            .arst_n    (arst_n),
            .clear     (flush),
            .push      (bank_push[b]),
            .push_data (bank_in[b]),
            .pop       (bank_pop[b]),
            .pop_data  (bank_out[b]),
            .full      (bank_full[b]),
            .empty     (bank_empty[b])
        );
    end

    // Output lane j reads the j-th bank after the read pointer
    for (genvar j = 0; j < DW; j++) begin : gen_out
        bank_idx_t src;

        assign src = rd_ptr + bank_idx_t'(j);

        always_comb begin
            decode_out[j] = '0;
            if (occ > occ_t'(j)) begin
                decode_out[j]       = bank_out[src];
                decode_out[j].valid = 1'b1;
            end
        end
    end

    // Pointers wrap modulo the bank count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            wr_ptr <= wr_ptr + bank_idx_t'(push_num);
            rd_ptr <= rd_ptr + bank_idx_t'(pop_num);
            occ    <= occ + occ_t'(push_num) - occ_t'(pop_num);
        end
    end

    // Backend may only take what is shown on decode_out
    a_accept_bound: assert property (@(posedge clk) disable iff (!arst_n)
        accept_cnt <= valid_lanes)
        else $error("instr_buffer: accept_cnt %0d above %0d valid lanes",
                    accept_cnt, valid_lanes);

    a_occ_bound: assert property (@(posedge clk) disable iff (!arst_n)
        occ <= occ_t'(SIZE))
        else $error("instr_buffer: occupancy %0d above size", occ);

    // Counter and bank flags must agree
    a_empty_sync: assert property (@(posedge clk) disable iff (!arst_n)
        (occ == '0) == (&bank_empty))
        else $error("instr_buffer: occupancy and bank empty flags disagree");

    a_full_sync: assert property (@(posedge clk) disable iff (!arst_n)
        (&bank_full) |-> (occ == occ_t'(SIZE)))
        else $error("instr_buffer: all banks full but occupancy is %0d", occ);

endmodule

// ==== hw/fetch_aligner.sv ====
`timescale 1ns/1ps
`include "ib_params.svh"

module fetch_aligner
    import ib_pkg::*;
(
    input  fetch_block_t fetch,
    output instr_info_t  lanes [`IB_FETCH_WIDTH],
    output push_cnt_t    push_cnt
);

    localparam int FW     = `IB_FETCH_WIDTH;
    localparam int XLEN   = `IB_XLEN;
    // Word slot bits inside a line, and byte offset bits of the line
    localparam int SLOT_W = $clog2(FW);
    localparam int OFF_W  = SLOT_W + 2;

    // First useful word of the block
    logic [SLOT_W-1:0] start_slot;

    assign start_slot = fetch.pc[OFF_W-1:2];

    // Words before the start slot belong to an earlier path
    assign push_cnt = fetch.valid ? push_cnt_t'(FW - int'(start_slot)) : '0;

    for (genvar i = 0; i < FW; i++) begin : gen_lane
        // One extra bit so a slot past the line end is detected
        logic [SLOT_W:0]   slot;
        logic [SLOT_W-1:0] slot_idx;
        logic              in_line;

        assign slot     = {1'b0, start_slot} + (SLOT_W + 1)'(i);
        assign slot_idx = slot[SLOT_W-1:0];
        assign in_line  = (slot < (SLOT_W + 1)'(FW));

        always_comb begin
            lanes[i] = '0;
            if (fetch.valid && in_line) begin
                lanes[i].valid = 1'b1;
                // Line base with the word slot put back in
                lanes[i].pc    = {fetch.pc[XLEN-1:OFF_W], slot_idx, 2'b00};
                lanes[i].instr = fetch.words[slot_idx];
            end
        end
    end

endmodule

// ==== hw/bank_fifo.sv ====
`timescale 1ns/1ps
`include "ib_params.svh"

module bank_fifo
    import ib_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clear,
    input  logic        push,
    input  instr_info_t push_data,
    input  logic        pop,
    output instr_info_t pop_data,
    output logic        full,
    output logic        empty
);

    localparam int DEPTH = `IB_SIZE / `IB_CHANNELS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    instr_info_t mem [DEPTH];
    ptr_t        rd_ptr;
    ptr_t        wr_ptr;
    cnt_t        count;

    // Wrap explicitly so a non power of two depth also works
    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Storage
    always_ff @(posedge clk) begin
        if (push && !clear) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is visible without a read cycle
    assign pop_data = mem[rd_ptr];
    assign full     = (count == cnt_t'(DEPTH));
    assign empty    = (count == '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        (push && !clear) |-> !full)
        else $error("bank_fifo: push into a full bank");

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        (pop && !clear) |-> !empty)
        else $error("bank_fifo: pop from an empty bank");

endmodule

// ==== hw/ib_pkg.sv ====
`include "ib_params.svh"

package ib_pkg;

    // One instruction slot as stored in the banks and sent to decode
    typedef struct packed {
        logic                valid;
        logic [`IB_XLEN-1:0] pc;
        logic [`IB_XLEN-1:0] instr;
    } instr_info_t;

    // Raw fetch block from one aligned line
    // words[0] is the lowest address in the line
    typedef struct packed {
        logic                                     valid;
        logic [`IB_XLEN-1:0]                      pc;
        logic [`IB_FETCH_WIDTH-1:0][`IB_XLEN-1:0] words;
    } fetch_block_t;

    // 0 .. fetch width
    typedef logic [$clog2(`IB_FETCH_WIDTH+1)-1:0] push_cnt_t;

    // 0 .. decode width
    typedef logic [$clog2(`IB_DECODE_WIDTH+1)-1:0] pop_cnt_t;

    // Selects one FIFO bank
    typedef logic [$clog2(`IB_CHANNELS)-1:0] bank_idx_t;

    // 0 .. buffer size
    typedef logic [$clog2(`IB_SIZE+1)-1:0] occ_t;

endpackage

// ==== hw/ib_params.svh ====
`ifndef IB_PARAMS_SVH
`define IB_PARAMS_SVH

// Instructions carried by one fetch block
`define IB_FETCH_WIDTH 4

// Output lanes toward decode
`define IB_DECODE_WIDTH 2

// FIFO banks, at least max(fetch width, decode width)
`define IB_CHANNELS 4

// Total instruction slots, split evenly across the banks
`define IB_SIZE 16

// PC and instruction word width
`define IB_XLEN 32

`endif
